// ==== design/cpu_pkg.sv ====
package cpu_pkg;

	localparam int XLEN      = 32;
	localparam int REG_IDX_W = 4; // RV32E, x0..x15.

	typedef enum logic [6:0] {
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011,
		LUI    = 7'b0110111,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [2:0] {
		ST_FETCH,
		ST_EXEC,
		ST_MEM,
		ST_WB,
		ST_HALT
	} core_state_e;

endpackage

// ==== design/bus_pkg.sv ====
package bus_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_e;

endpackage

// ==== design/mem_bus_if.sv ====
`timescale 1ns/1ps

interface mem_bus_if import bus_pkg::*; ();

	logic              ar_valid, ar_ready;
	logic [ADDR_W-1:0] ar_addr;
	logic              r_valid, r_ready;
	logic [DATA_W-1:0] r_data;
	resp_e             r_resp;
	logic              aw_valid, aw_ready;
	logic [ADDR_W-1:0] aw_addr;
	logic              w_valid, w_ready;
	logic [DATA_W-1:0] w_data;
	logic [STRB_W-1:0] w_strb;
	logic              b_valid, b_ready;
	resp_e             b_resp;

	modport master (
		output ar_valid, ar_addr, r_ready, aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
		input  ar_ready, r_valid, r_data, r_resp, aw_ready, w_ready, b_valid, b_resp
	);

	modport slave (
		input  ar_valid, ar_addr, r_ready, aw_valid, aw_addr, w_valid, w_data, w_strb, b_ready,
		output ar_ready, r_valid, r_data, r_resp, aw_ready, w_ready, b_valid, b_resp
	);

endinterface

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; #(
	parameter int NUM_REGS = 16
) (
	input  logic                 clock,
	input  logic [REG_IDX_W-1:0] rs1_idx, rs2_idx,
	output logic [XLEN-1:0]      rs1_data, rs2_data,
	input  logic                 wr_en,
	input  logic [REG_IDX_W-1:0] rd_idx,
	input  logic [XLEN-1:0]      rd_data
);

	logic [XLEN-1:0] regs [NUM_REGS];

	always_ff @(posedge clock) begin
		if (wr_en && rd_idx != '0) begin
			regs[rd_idx] <= rd_data;
		end
	end

	// x0 is never written, so mask the read.
	assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
	assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

// ==== design/core_control.sv ====
`timescale 1ns/1ps

module core_control import cpu_pkg::*, bus_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000
) (
	input  logic            clock,
	input  logic            rst_n,
	mem_bus_if.master       bus,
	input  logic            exec_done,
	input  logic [XLEN-1:0] next_pc,
	input  logic            is_mem, is_halt,
	input  logic            mem_done, mem_error,
	output core_state_e     state,
	output logic [XLEN-1:0] instr, pc,
	output logic            retire,
	output logic [XLEN-1:0] retire_pc,
	output logic            halted, bus_error
);

	logic ar_pend;
	logic r_wait;
	logic r_fire;

	assign bus.ar_valid = ar_pend;
	assign bus.ar_addr  = pc;
	assign bus.r_ready  = r_wait;
	assign r_fire       = bus.r_valid && bus.r_ready;

	// Fetch only reads.
	assign bus.aw_valid = 1'b0;
	assign bus.aw_addr  = '0;
	assign bus.w_valid  = 1'b0;
	assign bus.w_data   = '0;
	assign bus.w_strb   = '0;
	assign bus.b_ready  = 1'b0;

	assign retire    = (state == ST_WB);
	assign retire_pc = pc;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state     <= ST_FETCH;
			pc        <= RESET_PC;
			ar_pend   <= 1'b0;
			r_wait    <= 1'b0;
			halted    <= 1'b0;
			bus_error <= 1'b0;
		end else begin
			case (state)
				ST_FETCH: begin
					if (!ar_pend && !r_wait) begin
						ar_pend <= 1'b1; // First fetch after reset.
					end
					if (bus.ar_valid && bus.ar_ready) begin
						ar_pend <= 1'b0;
						r_wait  <= 1'b1;
					end
					if (r_fire) begin
						r_wait <= 1'b0;
						if (bus.r_resp != RESP_OKAY) begin
							state     <= ST_HALT;
							bus_error <= 1'b1;
						end else begin
							state <= ST_EXEC;
						end
					end
				end
				ST_EXEC: begin
					if (exec_done) begin
						if (is_mem) begin
							state <= ST_MEM;
						end else begin
							state <= ST_WB;
						end
					end
				end
				ST_MEM: begin
					if (mem_done && mem_error) begin
						state     <= ST_HALT;
						bus_error <= 1'b1;
					end else if (mem_done) begin
						state <= ST_WB;
					end
				end
				ST_WB: begin
					pc <= next_pc;
					if (is_halt) begin
						state  <= ST_HALT;
						halted <= 1'b1;
					end else begin
						state   <= ST_FETCH;
						ar_pend <= 1'b1; // Next fetch right after retire.
					end
				end
				default: state <= ST_HALT;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == ST_FETCH && r_fire) begin
			instr <= bus.r_data;
		end
	end

endmodule

// ==== design/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit import cpu_pkg::*; (
	input  logic [XLEN-1:0]      instr,
	output alu_op_e              alu_op,
	output logic [XLEN-1:0]      imm,
	output logic [REG_IDX_W-1:0] rs1_idx, rs2_idx, rd_idx,
	output logic                 reg_wr, use_imm,
	output logic                 is_load, is_store, is_branch, is_jal, is_halt
);

	opcode_e         opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

	assign opcode  = opcode_e'(instr[6:0]);
	assign funct3  = instr[14:12];
	assign funct7  = instr[31:25];
	assign rd_idx  = instr[7+:REG_IDX_W];
	assign rs1_idx = instr[15+:REG_IDX_W];
	assign rs2_idx = instr[20+:REG_IDX_W];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		alu_op    = ALU_ADD;
		imm       = imm_i;
		reg_wr    = 1'b0;
		use_imm   = 1'b0;
		is_load   = 1'b0;
		is_store  = 1'b0;
		is_branch = 1'b0;
		is_jal    = 1'b0;
		is_halt   = 1'b0;
		case (opcode)
			OP_IMM: begin
				reg_wr  = (funct3 == 3'b000); // ADDI.
				use_imm = 1'b1;
				is_halt = (funct3 != 3'b000);
			end
			OP: begin
				if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
					reg_wr = 1'b1;
				end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
					alu_op = ALU_SUB;
					reg_wr = 1'b1;
				end else begin
					is_halt = 1'b1;
				end
			end
			LUI: begin
				alu_op  = ALU_PASS_B;
				imm     = imm_u;
				use_imm = 1'b1;
				reg_wr  = 1'b1;
			end
			LOAD: begin
				use_imm = 1'b1;
				reg_wr  = (funct3 == 3'b010); // LW only.
				is_load = (funct3 == 3'b010);
				is_halt = (funct3 != 3'b010);
			end
			STORE: begin
				imm      = imm_s;
				use_imm  = 1'b1;
				is_store = (funct3 == 3'b010);
				is_halt  = (funct3 != 3'b010);
			end
			BRANCH: begin
				imm       = imm_b;
				is_branch = (funct3 == 3'b000); // BEQ only.
				is_halt   = (funct3 != 3'b000);
			end
			JAL: begin
				imm    = imm_j;
				reg_wr = 1'b1;
				is_jal = 1'b1;
			end
			default: is_halt = 1'b1; // EBREAK and anything unsupported.
		endcase
	end

endmodule

// ==== design/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit import cpu_pkg::*; (
	input  logic [XLEN-1:0] pc,
	input  logic [XLEN-1:0] rs1_data, rs2_data,
	input  logic [XLEN-1:0] imm,
	input  alu_op_e         alu_op,
	input  logic            use_imm,
	input  logic            is_branch, is_jal,
	output logic [XLEN-1:0] alu_result,
	output logic [XLEN-1:0] next_pc
);

	logic [XLEN-1:0] operand_b;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] target;
	logic            taken;

	assign operand_b = use_imm ? imm : rs2_data;
	assign pc_plus4  = pc + XLEN'(4);
	assign target    = pc + imm;
	assign taken     = is_branch && (rs1_data == rs2_data);

	always_comb begin
		case (alu_op)
			ALU_SUB:    alu_result = rs1_data - operand_b;
			ALU_PASS_B: alu_result = operand_b;
			default:    alu_result = rs1_data + operand_b;
		endcase
		if (is_jal) begin
			alu_result = pc_plus4; // Link value.
		end
	end

	assign next_pc = (taken || is_jal) ? target : pc_plus4;

endmodule

// ==== design/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit import bus_pkg::*; (
	input  logic              clock,
	input  logic              rst_n,
	mem_bus_if.master         bus,
	input  logic              start,
	input  logic              is_load, is_store,
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0] store_data,
	output logic [DATA_W-1:0] load_data,
	output logic              done,
	output logic              error
);

	logic busy;
	logic ar_pend, aw_pend, w_pend;
	logic r_fire, b_fire;

	assign bus.ar_valid = ar_pend;
	assign bus.ar_addr  = addr;
	assign bus.aw_valid = aw_pend;
	assign bus.aw_addr  = addr;
	assign bus.w_valid  = w_pend;
	assign bus.w_data   = store_data;
	assign bus.w_strb   = {STRB_W{1'b1}}; // Word access only.

	// Response is accepted once the request side has gone through.
	assign bus.r_ready = busy && is_load && !ar_pend;
	assign bus.b_ready = busy && is_store && !aw_pend && !w_pend;

	assign r_fire = bus.r_valid && bus.r_ready;
	assign b_fire = bus.b_valid && bus.b_ready;
	assign done   = r_fire || b_fire;
	assign error  = (r_fire && bus.r_resp != RESP_OKAY) || (b_fire && bus.b_resp != RESP_OKAY);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			ar_pend <= 1'b0;
			aw_pend <= 1'b0;
			w_pend  <= 1'b0;
		end else begin
			if (!busy && start) begin
				busy    <= is_load || is_store;
				ar_pend <= is_load;
				aw_pend <= is_store;
				w_pend  <= is_store;
			end
			if (ar_pend && bus.ar_ready) begin
				ar_pend <= 1'b0;
			end
			if (aw_pend && bus.aw_ready) begin
				aw_pend <= 1'b0;
			end
			if (w_pend && bus.w_ready) begin
				w_pend <= 1'b0;
			end
			if (done) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (r_fire) begin
			load_data <= bus.r_data;
		end
	end

endmodule

// ==== design/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter import bus_pkg::*; (
	input  logic              clock,
	input  logic              rst_n,
	mem_bus_if.slave          fetch_bus,
	mem_bus_if.slave          data_bus,
	output logic              ar_valid,
	input  logic              ar_ready,
	output logic [ADDR_W-1:0] ar_addr,
	input  logic              r_valid,
	output logic              r_ready,
	input  logic [DATA_W-1:0] r_data,
	input  logic [1:0]        r_resp,
	output logic              aw_valid,
	input  logic              aw_ready,
	output logic [ADDR_W-1:0] aw_addr,
	output logic              w_valid,
	input  logic              w_ready,
	output logic [DATA_W-1:0] w_data,
	output logic [STRB_W-1:0] w_strb,
	input  logic              b_valid,
	output logic              b_ready,
	input  logic [1:0]        b_resp
);

	logic rd_sel_data, wr_sel_data;
	logic rd_owner_data, wr_owner_data; // Who gets the pending r / b.

	// Data side wins when both request.
	assign rd_sel_data = data_bus.ar_valid;
	assign wr_sel_data = data_bus.aw_valid || data_bus.w_valid;

	assign ar_valid           = data_bus.ar_valid || fetch_bus.ar_valid;
	assign ar_addr            = rd_sel_data ? data_bus.ar_addr : fetch_bus.ar_addr;
	assign data_bus.ar_ready  = ar_ready && rd_sel_data;
	assign fetch_bus.ar_ready = ar_ready && !rd_sel_data;

	assign r_ready           = rd_owner_data ? data_bus.r_ready : fetch_bus.r_ready;
	assign data_bus.r_valid  = r_valid && rd_owner_data;
	assign fetch_bus.r_valid = r_valid && !rd_owner_data;
	assign data_bus.r_data   = r_data;
	assign fetch_bus.r_data  = r_data;
	assign data_bus.r_resp   = resp_e'(r_resp);
	assign fetch_bus.r_resp  = resp_e'(r_resp);

	assign aw_valid           = data_bus.aw_valid || fetch_bus.aw_valid;
	assign aw_addr            = wr_sel_data ? data_bus.aw_addr : fetch_bus.aw_addr;
	assign data_bus.aw_ready  = aw_ready && wr_sel_data;
	assign fetch_bus.aw_ready = aw_ready && !wr_sel_data;

	assign w_valid           = data_bus.w_valid || fetch_bus.w_valid;
	assign w_data            = wr_sel_data ? data_bus.w_data : fetch_bus.w_data;
	assign w_strb            = wr_sel_data ? data_bus.w_strb : fetch_bus.w_strb;
	assign data_bus.w_ready  = w_ready && wr_sel_data;
	assign fetch_bus.w_ready = w_ready && !wr_sel_data;

	assign b_ready           = wr_owner_data ? data_bus.b_ready : fetch_bus.b_ready;
	assign data_bus.b_valid  = b_valid && wr_owner_data;
	assign fetch_bus.b_valid = b_valid && !wr_owner_data;
	assign data_bus.b_resp   = resp_e'(b_resp);
	assign fetch_bus.b_resp  = resp_e'(b_resp);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rd_owner_data <= 1'b0;
			wr_owner_data <= 1'b0;
		end else begin
			if (ar_valid && ar_ready) begin
				rd_owner_data <= rd_sel_data;
			end
			if (aw_valid && aw_ready) begin
				wr_owner_data <= wr_sel_data;
			end
		end
	end

endmodule

// ==== design/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*, bus_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000,
	parameter int              NUM_REGS = 16
) (
	input  logic              clock,
	input  logic              rst_n,
	output logic              ar_valid,
	input  logic              ar_ready,
	output logic [ADDR_W-1:0] ar_addr,
	input  logic              r_valid,
	output logic              r_ready,
	input  logic [DATA_W-1:0] r_data,
	input  logic [1:0]        r_resp,
	output logic              aw_valid,
	input  logic              aw_ready,
	output logic [ADDR_W-1:0] aw_addr,
	output logic              w_valid,
	input  logic              w_ready,
	output logic [DATA_W-1:0] w_data,
	output logic [STRB_W-1:0] w_strb,
	input  logic              b_valid,
	output logic              b_ready,
	input  logic [1:0]        b_resp,
	output logic              retire,
	output logic [XLEN-1:0]   retire_pc,
	output logic              halted,
	output logic              bus_error
);

	mem_bus_if fetch_bus ();
	mem_bus_if data_bus ();

	core_state_e          state;
	logic [XLEN-1:0]      instr, pc, imm;
	alu_op_e              alu_op;
	logic [REG_IDX_W-1:0] rs1_idx, rs2_idx, rd_idx;
	logic                 reg_wr, use_imm;
	logic                 is_load, is_store, is_branch, is_jal, is_halt;
	logic [XLEN-1:0]      rs1_data, rs2_data, rd_data;
	logic [XLEN-1:0]      alu_result, next_pc;
	logic [DATA_W-1:0]    load_data;
	logic                 lsu_done, lsu_error;
	logic                 exec_done, is_mem, start, wr_en;

	assign exec_done = (state == ST_EXEC); // Single-cycle ALU.
	assign is_mem    = is_load || is_store;
	assign start     = (state == ST_MEM);
	assign wr_en     = reg_wr && (state == ST_WB);
	assign rd_data   = is_load ? load_data : alu_result;

	core_control #(
		.RESET_PC(RESET_PC)
	) u_control (
		.*,
		.bus(fetch_bus),
		.mem_done(lsu_done),
		.mem_error(lsu_error)
	);

	decode_unit u_decode (.*);

	reg_file #(
		.NUM_REGS(NUM_REGS)
	) u_regs (.*);

	exec_unit u_exec (.*);

	load_store_unit u_lsu (
		.*,
		.bus(data_bus),
		.addr(alu_result),
		.store_data(rs2_data),
		.done(lsu_done),
		.error(lsu_error)
	);

	bus_arbiter u_arbiter (.*);

endmodule

// ==== verif/cpu_properties.sv ====
`timescale 1ns/1ps

module cpu_properties (
	input logic        clock,
	input logic        rst_n,
	input logic        ar_valid, ar_ready,
	input logic [31:0] ar_addr,
	input logic        aw_valid, aw_ready,
	input logic [31:0] aw_addr,
	input logic        w_valid, w_ready,
	input logic [31:0] w_data,
	input logic        retire, halted, bus_error
);

	ar_hold: assert property (@(posedge clock) disable iff (!rst_n)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
		else $error("ar_valid dropped or ar_addr changed before ar_ready");

	aw_hold: assert property (@(posedge clock) disable iff (!rst_n)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
		else $error("aw_valid dropped or aw_addr changed before aw_ready");

	w_hold: assert property (@(posedge clock) disable iff (!rst_n)
		w_valid && !w_ready |=> w_valid && $stable(w_data))
		else $error("w_valid dropped or w_data changed before w_ready");

	// Stopped core stays off the bus.
	quiet_stop: assert property (@(posedge clock) disable iff (!rst_n)
		halted || bus_error |-> !ar_valid && !aw_valid && !w_valid)
		else $error("bus request while halted");

	retire_pulse: assert property (@(posedge clock) disable iff (!rst_n)
		retire |=> !retire)
		else $error("retire held longer than one cycle");

endmodule

bind cpu_top cpu_properties props (.*);

// ==== verif/tb_top.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clock
);
	initial clock = 1'b0;
	always #20 clock = ~clock; // 40 ns period.
endmodule

module tb_top;

	localparam logic [31:0] BASE = 32'h8000_0000;
	localparam int MAX_CYCLES = 3000; // Seven runs of under 150 cycles, some slowed by back-pressure.

	logic clock, rst_n;
	logic ar_valid, ar_ready, r_valid, r_ready, aw_valid, aw_ready;
	logic w_valid, w_ready, b_valid, b_ready, retire, halted, bus_error;
	logic [31:0] ar_addr, r_data, aw_addr, w_data, retire_pc;
	logic [3:0] w_strb;
	logic [1:0] r_resp, b_resp;

	logic [31:0] mem [1024];
	logic [31:0] rd_addr, wr_addr, wr_data, err_addr;
	logic rd_busy, aw_got, w_got, strb_bad, random_delays;
	logic [15:0] lfsr;
	logic [31:0] prog[$], retire_log[$], exp_pcs[$];
	int cycles, errors, checks, test_errors;

	tb_clock clk_gen (.clock(clock));

	cpu_top DUT (.*);

	function automatic logic lfsr_bit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out) lfsr = lfsr ^ 16'hB400;
		return out;
	endfunction

	function automatic logic ready_now();
		if (!random_delays) return 1'b1;
		return lfsr_bit();
	endfunction

	function automatic logic [31:0] addi(logic [4:0] rd, logic [4:0] rs1, logic [31:0] imm);
		return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
	endfunction
	function automatic logic [31:0] add_reg(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
		return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
	endfunction
	function automatic logic [31:0] sub_reg(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
		return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
	endfunction
	function automatic logic [31:0] lui(logic [4:0] rd, logic [19:0] imm);
		return {imm, rd, 7'b0110111};
	endfunction
	function automatic logic [31:0] lw(logic [4:0] rd, logic [4:0] rs1, logic [31:0] imm);
		return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
	endfunction
	function automatic logic [31:0] sw(logic [4:0] rs2, logic [4:0] rs1, logic [31:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction
	function automatic logic [31:0] beq(logic [4:0] rs1, logic [4:0] rs2, logic [31:0] off);
		return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
	endfunction
	function automatic logic [31:0] jal(logic [4:0] rd, logic [31:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	// Memory model, one request per channel at a time.
	always @(posedge clock) begin
		if (!rst_n) begin
			ar_ready <= 1'b0;
			r_valid  <= 1'b0;
			r_data   <= '0;
			r_resp   <= 2'b00;
			aw_ready <= 1'b0;
			w_ready  <= 1'b0;
			b_valid  <= 1'b0;
			b_resp   <= 2'b00;
			rd_busy  <= 1'b0;
			aw_got   <= 1'b0;
			w_got    <= 1'b0;
			strb_bad <= 1'b0;
		end else begin
			ar_ready <= ar_valid && !ar_ready && !rd_busy && ready_now();
			if (ar_valid && ar_ready) begin
				rd_busy <= 1'b1;
				rd_addr <= ar_addr;
			end
			if (r_valid && r_ready) begin
				r_valid <= 1'b0;
				rd_busy <= 1'b0;
			end else if (rd_busy && !r_valid && ready_now()) begin
				r_valid <= 1'b1;
				r_data  <= mem[rd_addr[11:2]];
				r_resp  <= (rd_addr == err_addr) ? 2'b10 : 2'b00;
			end
			aw_ready <= aw_valid && !aw_ready && !aw_got && ready_now();
			w_ready  <= w_valid && !w_ready && !w_got && ready_now();
			if (aw_valid && aw_ready) begin
				aw_got  <= 1'b1;
				wr_addr <= aw_addr;
			end
			if (w_valid && w_ready) begin
				w_got   <= 1'b1;
				wr_data <= w_data;
				if (w_strb != 4'hF) strb_bad <= 1'b1;
			end
			if (b_valid && b_ready) begin
				b_valid <= 1'b0;
				aw_got  <= 1'b0;
				w_got   <= 1'b0;
			end else if (aw_got && w_got && !b_valid && ready_now()) begin
				b_valid <= 1'b1;
				b_resp  <= (wr_addr == err_addr) ? 2'b10 : 2'b00;
				if (wr_addr != err_addr) mem[wr_addr[11:2]] <= wr_data;
			end
		end
	end

	always @(posedge clock) begin
		if (rst_n && retire) retire_log.push_back(retire_pc);
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the core never halted", cycles);
			$display("test failed");
			$finish;
		end
	end

	task automatic load_and_run();
		@(posedge clock);
		rst_n <= 1'b0;
		for (int i = 0; i < 1024; i++) begin
			mem[i] <= 32'h5A5A_0000 ^ (i << 2); // Address-dependent fill.
		end
		foreach (prog[i]) mem[i] <= prog[i];
		retire_log.delete();
		repeat (8) @(posedge clock);
		rst_n <= 1'b1;
		@(posedge clock);
		while (!halted && !bus_error) @(posedge clock);
	endtask

	task automatic check_word(string name, logic [31:0] addr, logic [31:0] exp);
		checks++;
		if (mem[addr[11:2]] !== exp) begin
			$display("Mismatch in %s at %h: expected %h, actual %h", name, addr, exp,
				mem[addr[11:2]]);
			errors++;
		end
	endtask

	task automatic check_true(logic cond, string what);
		checks++;
		if (!cond) begin
			$display("Error: %s", what);
			errors++;
		end
	endtask

	task automatic check_retires(string name);
		checks++;
		if (retire_log.size() != exp_pcs.size()) begin
			$display("Mismatch in %s retire count: expected %0d, actual %0d", name,
				exp_pcs.size(), retire_log.size());
			errors++;
		end else begin
			foreach (exp_pcs[i]) begin
				if (retire_log[i] !== exp_pcs[i]) begin
					$display("Mismatch in %s retire %0d: expected %h, actual %h", name, i,
						exp_pcs[i], retire_log[i]);
					errors++;
				end
			end
		end
	endtask

	task automatic check_quiet(string name);
		int busy_cycles;
		busy_cycles = 0;
		repeat (20) begin
			@(posedge clock);
			if (ar_valid || aw_valid || w_valid) busy_cycles++;
		end
		check_true(busy_cycles == 0, {name, ": bus request made after the core stopped"});
	endtask

	task automatic finish_test(string name);
		$display("%s: %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	task automatic build_arith();
		prog = {lui(15, 20'h80000), addi(1, 0, 100), addi(2, 0, -7), add_reg(3, 1, 2),
			sub_reg(4, 2, 1), lui(5, 20'h12345), addi(0, 1, 5), sw(3, 15, 32'h400),
			sw(4, 15, 32'h404), sw(5, 15, 32'h408), sw(0, 15, 32'h40c), 32'h0010_0073};
		exp_pcs.delete();
		for (int i = 0; i < 12; i++) exp_pcs.push_back(BASE + 32'(i * 4));
	endtask

	task automatic verify_arith(string name);
		logic [31:0] a, b;
		a = 32'd100;
		b = -32'sd7;
		check_word({name, " add"}, BASE + 32'h400, a + b);
		check_word({name, " sub"}, BASE + 32'h404, b - a);
		check_word({name, " lui"}, BASE + 32'h408, 32'h12345 << 12);
		check_word({name, " x0"}, BASE + 32'h40c, 32'h0);
		check_true(!strb_bad, {name, ": store with a partial write strobe"});
		check_true(halted && !bus_error, {name, ": core did not halt cleanly"});
		check_retires(name);
	endtask

	task automatic test_arith();
		build_arith();
		load_and_run();
		verify_arith("arith");
		finish_test("arithmetic");
	endtask

	task automatic test_backpressure();
		random_delays = 1'b1;
		build_arith();
		load_and_run();
		verify_arith("backpressure");
		random_delays = 1'b0;
		finish_test("back-pressure");
	endtask

	task automatic test_load_store();
		logic [31:0] pre;
		pre = 32'h0000_1234;
		prog = {lui(15, 20'h80000), addi(1, 0, 55), sw(1, 15, 32'h414), lw(2, 15, 32'h414),
			addi(2, 2, 1), sw(2, 15, 32'h418), lw(3, 15, 32'h410), addi(3, 3, 2),
			sw(3, 15, 32'h41c), 32'h0010_0073};
		for (int i = prog.size(); i < 260; i++) prog.push_back(32'h5A5A_0000 ^ 32'(i << 2));
		prog.push_back(pre); // Preloaded word at offset 0x410.
		load_and_run();
		check_word("reload", BASE + 32'h418, 32'd55 + 32'd1);
		check_word("preload", BASE + 32'h41c, pre + 32'd2);
		check_word("preload kept", BASE + 32'h410, pre);
		check_true(halted && !bus_error, "load/store: core did not halt cleanly");
		finish_test("load/store");
	endtask

	task automatic test_control_flow();
		prog = {lui(15, 20'h80000), addi(2, 0, 0), addi(1, 0, 5), beq(1, 0, 8), beq(1, 1, 8),
			addi(2, 0, 99), jal(3, 8), addi(2, 0, 77), sw(3, 15, 32'h420), sw(2, 15, 32'h424),
			32'h0010_0073};
		exp_pcs = {BASE, BASE + 4, BASE + 8, BASE + 12, BASE + 16, BASE + 24, BASE + 32,
			BASE + 36, BASE + 40};
		load_and_run();
		check_word("jal link", BASE + 32'h420, BASE + 24 + 4);
		check_word("skipped writes", BASE + 32'h424, 32'h0);
		check_retires("control flow");
		finish_test("control flow");
	endtask

	task automatic test_bus_error();
		err_addr = BASE + 32'h430;
		prog = {lui(15, 20'h80000), addi(1, 0, 1), lw(2, 15, 32'h430), sw(1, 15, 32'h434),
			32'h0010_0073};
		exp_pcs = {BASE, BASE + 4}; // The failing load never retires.
		load_and_run();
		check_true(bus_error && !halted, "bus error: bus_error not raised alone");
		check_retires("bus error");
		check_quiet("bus error");
		check_word("no store", BASE + 32'h434, 32'h5A5A_0000 ^ 32'h434);
		err_addr = '1;
		finish_test("bus error");
	endtask

	task automatic test_halt();
		prog = {addi(1, 0, 3), 32'h0010_0073, addi(1, 0, 4)};
		exp_pcs = {BASE, BASE + 4};
		load_and_run();
		check_true(halted && !bus_error, "halt: EBREAK did not halt");
		check_retires("ebreak");
		check_quiet("ebreak");
		prog = {addi(1, 0, 3), {7'h00, 5'd2, 5'd1, 3'b111, 5'd3, 7'b0110011}, addi(1, 0, 4)};
		load_and_run();
		check_true(halted && !bus_error, "halt: unsupported opcode did not halt");
		check_retires("unsupported");
		check_quiet("unsupported");
		finish_test("halt");
	endtask

	initial begin
		rst_n <= 1'b0;
		ar_ready <= 1'b0;
		r_valid <= 1'b0;
		r_data <= '0;
		r_resp <= 2'b00;
		aw_ready <= 1'b0;
		w_ready <= 1'b0;
		b_valid <= 1'b0;
		b_resp <= 2'b00;
		lfsr = 16'd38300;
		random_delays = 1'b0;
		err_addr = '1;
		test_arith();
		test_load_store();
		test_control_flow();
		test_backpressure();
		test_bus_error();
		test_halt();
		$display("Checks: %0d run, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
design/cpu_pkg.sv
design/bus_pkg.sv
design/mem_bus_if.sv
design/reg_file.sv
design/core_control.sv
design/decode_unit.sv
design/exec_unit.sv
design/load_store_unit.sv
design/bus_arbiter.sv
design/cpu_top.sv
verif/cpu_properties.sv
verif/tb_top.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_top -f compile.f -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
